// File: tb.f
+incdir+verilog
verilog/dsp_types_pkg.sv
verilog/dsp_cfg_pkg.sv
verilog/dsp_cfg_if.sv
verilog/dsp_ctrl.sv
verilog/ffe_filter.sv
verilog/bit_slicer.sv
verilog/channel_error.sv
verilog/error_detector.sv
verilog/dsp_top.sv
bench/dsp_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --top-module dsp_tb -f tb.f -o dsp_sim \
    && ./obj_dir/dsp_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1

// File: bench/dsp_tb.sv
`include "dsp_defs.svh"

module dsp_tb
    import dsp_types_pkg::*;
    import dsp_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk;
    logic       reset_i;
    logic       cfg_we_i;
    cfg_kind_e  cfg_kind_i;
    cfg_word_u  cfg_data_i;
    logic       adc_valid_i;
    code_word_t adc_codes_i;
    logic       out_valid_o;
    bit_word_t  bits_o;
    err_word_t  err_o;
    pos_word_t  err_pos_o;

    integer seed;

    // Configuration as written, plain integers
    int w_m    [`DSP_LANES][`FFE_TAPS];
    int chan_m [`DSP_LANES][`CHAN_TAPS];
    int thr_m  [`DSP_LANES];
    int fsh_m  [`DSP_LANES];
    int csh_m  [`DSP_LANES];
    int align_m;

    // Model history over accepted words
    code_word_t prev_code;
    code_word_t code_d1;
    code_word_t code_d2;
    bit_word_t  prev_raw;
    bit_word_t  prev_bits;

    bit_word_t exp_bits_q[$];
    err_word_t exp_err_q[$];
    pos_word_t exp_pos_q[$];
    int        pos_seen[3];

    dsp_top DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_kind_i  (cfg_kind_i),
        .cfg_data_i  (cfg_data_i),
        .adc_valid_i (adc_valid_i),
        .adc_codes_i (adc_codes_i),
        .out_valid_o (out_valid_o),
        .bits_o      (bits_o),
        .err_o       (err_o),
        .err_pos_o   (err_pos_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // Keep the low bits of v as a signed number
    function automatic int wrap_signed(input int v, input int width);
        return (v <<< (32 - width)) >>> (32 - width);
    endfunction

    function automatic code_word_t random_word();
        code_word_t w;
        for (int l = 0; l < `DSP_LANES; l++) begin
            w[l] = code_t'(rand_range(-128, 127));
        end
        return w;
    endfunction

    function automatic code_word_t fill_word(input int v);
        code_word_t w;
        for (int l = 0; l < `DSP_LANES; l++) begin
            w[l] = code_t'(v);
        end
        return w;
    endfunction

    function automatic void model_word(input code_word_t w, output bit_word_t b,
                                       output err_word_t e, output pos_word_t p);
        int                      x   [2*`DSP_LANES];
        int                      sym [2*`DSP_LANES];
        logic [2*`DSP_LANES-1:0] raw_ser;
        logic [2*`DSP_LANES-1:0] bit_ser;
        bit_word_t               raw;
        int                      acc;
        int                      err;
        int                      d;
        int                      cost [3];
        for (int i = 0; i < `DSP_LANES; i++) begin
            x[i]              = int'(prev_code[i]);
            x[i + `DSP_LANES] = int'(w[i]);
        end
        // Equalize and slice, lane 0 earliest in the serial stream
        for (int l = 0; l < `DSP_LANES; l++) begin
            acc = 0;
            for (int k = 0; k < `FFE_TAPS; k++) begin
                acc += w_m[l][k] * x[`DSP_LANES + l - k];
            end
            acc    = wrap_signed(acc >>> fsh_m[l], `FFE_OUT_W);
            raw[l] = acc >= thr_m[l];
        end
        raw_ser = {raw, prev_raw};
        for (int l = 0; l < `DSP_LANES; l++) begin
            b[l] = raw_ser[l + align_m];
        end
        bit_ser = {b, prev_bits};
        for (int i = 0; i < 2*`DSP_LANES; i++) begin
            sym[i] = bit_ser[i] ? 1 : -1;
        end
        for (int l = 0; l < `DSP_LANES; l++) begin
            acc = 0;
            for (int k = 0; k < `CHAN_TAPS; k++) begin
                acc += chan_m[l][k] * sym[`DSP_LANES + l - k];
            end
            acc  = wrap_signed(acc >>> csh_m[l], `EST_W);
            err  = wrap_signed(acc - int'(code_d2[l]), `ERR_W);
            e[l] = err_t'(err);
            // No flip, this bit, this bit and the one before
            d       = err;
            cost[0] = d * d;
            d       = d - 2 * chan_m[l][0] * sym[`DSP_LANES + l];
            cost[1] = d * d;
            d       = d - 2 * chan_m[l][1] * sym[`DSP_LANES + l - 1];
            cost[2] = d * d;
            p[l]    = 2'd0;
            if (cost[1] < cost[0]) begin
                p[l] = 2'd1;
            end
            if (cost[2] < cost[int'(p[l])]) begin
                p[l] = 2'd2;
            end
        end
        prev_code = w;
        prev_raw  = raw;
        prev_bits = b;
        code_d2   = code_d1;
        code_d1   = w;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_bits(input bit_word_t got, input bit_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t bits_o got %h expected %h", $time, got, exp);
            abort_run("bits_o differs from the reference");
        end
    endtask

    task automatic check_err(input err_word_t got, input err_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t err_o got %h expected %h", $time, got, exp);
            abort_run("err_o differs from the reference");
        end
    endtask

    task automatic check_pos(input pos_word_t got, input pos_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t err_pos_o got %h expected %h", $time, got, exp);
            abort_run("err_pos_o differs from the reference");
        end
    endtask

    task automatic write_cfg(input cfg_kind_e kind, input int lane, input int idx,
                             input int value);
        cfg_word_u d;
        d = '0;
        if (kind == CFG_FFE_WEIGHT || kind == CFG_CHAN_TAP) begin
            d.tap.lane  = 8'(lane);
            d.tap.tap   = 8'(idx);
            d.tap.value = 16'(value);
        end else begin
            d.scalar.lane  = 8'(lane);
            d.scalar.value = 24'(value);
        end
        @(posedge clk);
        cfg_we_i   <= 1'b1;
        cfg_kind_i <= kind;
        cfg_data_i <= d;
        @(posedge clk);
        cfg_we_i <= 1'b0;
        case (kind)
            CFG_FFE_WEIGHT: w_m[lane][idx] = value;
            CFG_CHAN_TAP:   chan_m[lane][idx] = value;
            CFG_THRESH:     thr_m[lane] = value;
            CFG_FFE_SHIFT:  fsh_m[lane] = value;
            CFG_CHAN_SHIFT: csh_m[lane] = value;
            CFG_ALIGN:      align_m = value;
            default: begin
            end
        endcase
    endtask

    task automatic load_unit_ffe();
        for (int l = 0; l < `DSP_LANES; l++) begin
            for (int k = 0; k < `FFE_TAPS; k++) begin
                write_cfg(CFG_FFE_WEIGHT, l, k, (k == 0) ? 1 : 0);
            end
            write_cfg(CFG_FFE_SHIFT, l, 0, 0);
            write_cfg(CFG_THRESH, l, 0, 0);
        end
        write_cfg(CFG_ALIGN, 0, 0, 0);
    endtask

    task automatic send_word(input code_word_t w);
        bit_word_t b;
        err_word_t e;
        pos_word_t p;
        @(posedge clk);
        adc_valid_i <= 1'b1;
        adc_codes_i <= w;
        model_word(w, b, e, p);
        exp_bits_q.push_back(b);
        exp_err_q.push_back(e);
        exp_pos_q.push_back(p);
    endtask

    // Gap cycles carry junk codes
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            adc_valid_i <= 1'b0;
            adc_codes_i <= random_word();
        end
    endtask

    task automatic stream_random(input int count, input int max_gap);
        for (int i = 0; i < count; i++) begin
            send_word(random_word());
            idle_cycles(rand_range(0, max_gap));
        end
    endtask

    task automatic drain();
        int n;
        idle_cycles(1);
        n = 0;
        while (exp_bits_q.size() != 0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (exp_bits_q.size() != 0) begin
            abort_run("timeout: out_valid_o never came for the queued words");
        end
    endtask

    // Compare at the falling edge, away from the DUT's updates
    initial begin
        pos_word_t exp_p;
        forever begin
            @(negedge clk);
            if (out_valid_o === 1'b1) begin
                if (exp_bits_q.size() == 0) begin
                    abort_run("out_valid_o high with no word outstanding");
                end else begin
                    exp_p = exp_pos_q.pop_front();
                    check_bits(bits_o, exp_bits_q.pop_front());
                    check_err(err_o, exp_err_q.pop_front());
                    check_pos(err_pos_o, exp_p);
                    for (int l = 0; l < `DSP_LANES; l++) begin
                        pos_seen[exp_p[l]]++;
                    end
                end
            end
        end
    end

    initial begin
        int n;
        int det_vals [10];
        seed        = 32'h289b;
        reset_i     = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_kind_i  = CFG_FFE_WEIGHT;
        cfg_data_i  = '0;
        adc_valid_i = 1'b0;
        adc_codes_i = '0;
        prev_code   = '0;
        code_d1     = '0;
        code_d2     = '0;
        prev_raw    = '0;
        prev_bits   = '0;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (out_valid_o !== 1'b0) begin
                $display("[FAIL] %0t out_valid_o got %b expected 0", $time, out_valid_o);
                abort_run("out_valid_o high after reset with no input");
            end
        end

        // One word, counted from the edge that drives the strobe
        send_word(random_word());
        n = 0;
        do begin
            @(posedge clk);
            adc_valid_i <= 1'b0;
            n++;
            @(negedge clk);
        end while (out_valid_o !== 1'b1 && n < 20);
        if (out_valid_o !== 1'b1) begin
            abort_run("timeout: out_valid_o never rose after a single word");
        end
        if (n != 5) begin
            $display("[FAIL] %0t out_valid_o latency got %0d expected %0d", $time, n, 5);
            abort_run("out_valid_o latency is wrong");
        end
        @(negedge clk);
        if (out_valid_o !== 1'b0) begin
            $display("[FAIL] %0t out_valid_o got %b expected 0", $time, out_valid_o);
            abort_run("out_valid_o stayed high for more than one cycle");
        end
        drain();

        load_unit_ffe();
        stream_random(40, 0);
        drain();

        for (int l = 0; l < `DSP_LANES; l++) begin
            for (int k = 0; k < `FFE_TAPS; k++) begin
                write_cfg(CFG_FFE_WEIGHT, l, k, rand_range(-128, 127));
            end
            write_cfg(CFG_FFE_SHIFT, l, 0, rand_range(0, 7));
            write_cfg(CFG_THRESH, l, 0, rand_range(-256, 255));
        end
        stream_random(100, 2);
        drain();

        for (int a = 0; a < `DSP_LANES; a++) begin
            write_cfg(CFG_ALIGN, 0, 0, a);
            stream_random(30, 1);
            drain();
        end

        for (int l = 0; l < `DSP_LANES; l++) begin
            for (int k = 0; k < `CHAN_TAPS; k++) begin
                write_cfg(CFG_CHAN_TAP, l, k, rand_range(-128, 127));
            end
            write_cfg(CFG_CHAN_SHIFT, l, 0, rand_range(0, 3));
        end
        stream_random(200, 3);
        drain();

        // Codes of 16 tie no flip with one flip
        // A 0 or a -32 two words back forces one or two flips
        load_unit_ffe();
        for (int l = 0; l < `DSP_LANES; l++) begin
            write_cfg(CFG_CHAN_TAP, l, 0, 16);
            write_cfg(CFG_CHAN_TAP, l, 1, 16);
            write_cfg(CFG_CHAN_TAP, l, 2, 0);
            write_cfg(CFG_CHAN_SHIFT, l, 0, 0);
        end
        pos_seen = '{0, 0, 0};
        det_vals = '{16, 16, 16, 16, 0, 16, 16, -32, 16, 16};
        for (int i = 0; i < 10; i++) begin
            send_word(fill_word(det_vals[i]));
        end
        drain();
        for (int i = 0; i < 3; i++) begin
            if (pos_seen[i] == 0) begin
                abort_run($sformatf("detector choice %0d never occurred", i));
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog/dsp_top.sv
`include "dsp_defs.svh"

module dsp_top
    import dsp_types_pkg::*;
    import dsp_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       cfg_we_i,
    input  cfg_kind_e  cfg_kind_i,
    input  cfg_word_u  cfg_data_i,
    input  logic       adc_valid_i,
    input  code_word_t adc_codes_i,
    output logic       out_valid_o,
    output bit_word_t  bits_o,
    output err_word_t  err_o,
    output pos_word_t  err_pos_o
);

    ffe_out_t [`DSP_LANES-1:0] eq;
    bit_word_t                 slice_bits;
    bit_word_t                 chan_bits;
    err_word_t                 chan_err;

    dsp_cfg_if cfg_if ();

    dsp_ctrl u_ctrl (
        .clk         (clk),
        .reset_i     (reset_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_kind_i  (cfg_kind_i),
        .cfg_data_i  (cfg_data_i),
        .adc_valid_i (adc_valid_i),
        .cfg         (cfg_if),
        .out_valid_o (out_valid_o)
    );

    ffe_filter u_ffe (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg     (cfg_if),
        .codes_i (adc_codes_i),
        .eq_o    (eq)
    );

    bit_slicer u_slicer (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg     (cfg_if),
        .eq_i    (eq),
        .bits_o  (slice_bits)
    );

    // Takes the raw ADC word for its own code delay
    channel_error u_chan (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg     (cfg_if),
        .bits_i  (slice_bits),
        .codes_i (adc_codes_i),
        .err_o   (chan_err),
        .bits_o  (chan_bits)
    );

    error_detector u_det (
        .clk       (clk),
        .reset_i   (reset_i),
        .cfg       (cfg_if),
        .err_i     (chan_err),
        .bits_i    (chan_bits),
        .err_pos_o (err_pos_o),
        .bits_o    (bits_o),
        .err_o     (err_o)
    );

endmodule

// File: verilog/error_detector.sv
`include "dsp_defs.svh"

module error_detector
    import dsp_types_pkg::*;
    import dsp_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    dsp_cfg_if.dp     cfg,
    input  err_word_t err_i,
    input  bit_word_t bits_i,
    output pos_word_t err_pos_o,
    output bit_word_t bits_o,
    output err_word_t err_o
);

    localparam int DIFF_W = `ERR_W + 3;
    localparam int SQ_W   = 2 * DIFF_W;

    bit_word_t               prev_q;
    logic [2*`DSP_LANES-1:0] ser;
    pos_word_t               pos_d;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_q <= '0;
        end else if (cfg.v_det) begin
            prev_q <= bits_i;
        end
    end

    // Lane 0 looks back into the previous word
    assign ser = {bits_i, prev_q};

    always_comb begin
        logic signed [DIFF_W-1:0] e;
        logic signed [DIFF_W-1:0] inj_s;
        logic signed [DIFF_W-1:0] inj_p;
        logic signed [DIFF_W-1:0] d1;
        logic signed [DIFF_W-1:0] d2;
        logic signed [SQ_W-1:0]   cost0;
        logic signed [SQ_W-1:0]   cost1;
        logic signed [SQ_W-1:0]   cost2;
        logic signed [SQ_W-1:0]   best;
        err_t                     err;
        chan_t                    h0;
        chan_t                    h1;
        for (int l = 0; l < `DSP_LANES; l++) begin
            err = err_i[l];
            h0  = cfg.chan[l][0];
            h1  = cfg.chan[l][1];
            e   = DIFF_W'(err);
            // A flip moves the symbol by two
            inj_s = DIFF_W'(h0) <<< 1;
            inj_p = DIFF_W'(h1) <<< 1;
            if (!ser[`DSP_LANES + l]) begin
                inj_s = -inj_s;
            end
            if (!ser[`DSP_LANES + l - 1]) begin
                inj_p = -inj_p;
            end
            d1    = e - inj_s;
            d2    = d1 - inj_p;
            cost0 = SQ_W'(e) * SQ_W'(e);
            cost1 = SQ_W'(d1) * SQ_W'(d1);
            cost2 = SQ_W'(d2) * SQ_W'(d2);
            // Strict compares keep the lower index on a tie
            pos_d[l] = 2'd0;
            best     = cost0;
            if (cost1 < best) begin
                pos_d[l] = 2'd1;
                best     = cost1;
            end
            if (cost2 < best) begin
                pos_d[l] = 2'd2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.v_det) begin
            err_pos_o <= pos_d;
            bits_o    <= bits_i;
            err_o     <= err_i;
        end
    end

endmodule

// File: verilog/channel_error.sv
`include "dsp_defs.svh"

module channel_error
    import dsp_types_pkg::*;
    import dsp_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    dsp_cfg_if.dp      cfg,
    input  bit_word_t  bits_i,
    input  code_word_t codes_i,
    output err_word_t  err_o,
    output bit_word_t  bits_o
);

    localparam int SUM_W = `CHAN_W + $clog2(`CHAN_TAPS) + 1;

    code_word_t              p0_q;
    code_word_t              p1_q;
    code_word_t              p2_q;
    code_word_t              d1_q;
    code_word_t              d2_q;
    bit_word_t               prev_q;
    logic [2*`DSP_LANES-1:0] ser;
    err_word_t               err_d;

    // Brings the accepted word up to the v_chan edge
    always_ff @(posedge clk) begin
        p0_q <= codes_i;
        p1_q <= p0_q;
        p2_q <= p1_q;
    end

    // Two-word code delay and previous bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_q <= '0;
            d1_q   <= '0;
            d2_q   <= '0;
        end else if (cfg.v_chan) begin
            prev_q <= bits_i;
            d1_q   <= p2_q;
            d2_q   <= d1_q;
        end
    end

    assign ser = {bits_i, prev_q};

    always_comb begin
        logic signed [SUM_W-1:0] acc;
        logic signed [SUM_W-1:0] sh;
        chan_t                   h;
        est_t                    est;
        code_t                   c;
        for (int l = 0; l < `DSP_LANES; l++) begin
            acc = '0;
            for (int k = 0; k < `CHAN_TAPS; k++) begin
                h = cfg.chan[l][k];
                // Bit 1 is symbol +1, bit 0 is -1
                if (ser[`DSP_LANES + l - k]) begin
                    acc = acc + SUM_W'(h);
                end else begin
                    acc = acc - SUM_W'(h);
                end
            end
            sh       = acc >>> cfg.chan_shift[l];
            est      = sh[`EST_W-1:0];
            c        = d2_q[l];
            err_d[l] = `ERR_W'(est) - `ERR_W'(c);
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.v_chan) begin
            err_o  <= err_d;
            bits_o <= bits_i;
        end
    end

endmodule

// File: verilog/bit_slicer.sv
`include "dsp_defs.svh"

module bit_slicer
    import dsp_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_i,
    dsp_cfg_if.dp                     cfg,
    input  ffe_out_t [`DSP_LANES-1:0] eq_i,
    output bit_word_t                 bits_o
);

    bit_word_t               raw;
    bit_word_t               prev_q;
    logic [2*`DSP_LANES-1:0] ser;
    logic [2*`DSP_LANES-1:0] shifted;

    always_comb begin
        ffe_out_t eq;
        ffe_out_t th;
        for (int l = 0; l < `DSP_LANES; l++) begin
            eq     = eq_i[l];
            th     = cfg.thresh[l];
            raw[l] = eq >= th;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_q <= '0;
        end else if (cfg.v_slice) begin
            prev_q <= raw;
        end
    end

    // Window starts at lane 0 of the previous raw word
    assign ser     = {raw, prev_q};
    assign shifted = ser >> cfg.align_pos;

    always_ff @(posedge clk) begin
        if (cfg.v_slice) begin
            bits_o <= shifted[`DSP_LANES-1:0];
        end
    end

endmodule

// File: verilog/ffe_filter.sv
`include "dsp_defs.svh"

module ffe_filter
    import dsp_types_pkg::*;
    import dsp_cfg_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_i,
    dsp_cfg_if.dp                     cfg,
    input  code_word_t                codes_i,
    output ffe_out_t [`DSP_LANES-1:0] eq_o
);

    localparam int SUM_W = `CODE_W + `WEIGHT_W + $clog2(`FFE_TAPS);

    code_word_t                in_q;
    code_word_t                prev_q;
    code_t [2*`DSP_LANES-1:0]  ser;
    ffe_out_t [`DSP_LANES-1:0] eq_d;

    // Input word, consumed on the following v_ffe
    always_ff @(posedge clk) begin
        in_q <= codes_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_q <= '0;
        end else if (cfg.v_ffe) begin
            prev_q <= in_q;
        end
    end

    // Previous word below the current one in serial order
    assign ser = {in_q, prev_q};

    always_comb begin
        logic signed [SUM_W-1:0] acc;
        logic signed [SUM_W-1:0] sh;
        weight_t                 w;
        code_t                   c;
        for (int l = 0; l < `DSP_LANES; l++) begin
            acc = '0;
            for (int k = 0; k < `FFE_TAPS; k++) begin
                w   = cfg.weight[l][k];
                c   = ser[`DSP_LANES + l - k];
                acc = acc + SUM_W'(w) * SUM_W'(c);
            end
            sh      = acc >>> cfg.ffe_shift[l];
            eq_d[l] = sh[`FFE_OUT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.v_ffe) begin
            eq_o <= eq_d;
        end
    end

endmodule

// File: verilog/dsp_ctrl.sv
`include "dsp_defs.svh"

module dsp_ctrl
    import dsp_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      cfg_we_i,
    input  cfg_kind_e cfg_kind_i,
    input  cfg_word_u cfg_data_i,
    input  logic      adc_valid_i,
    dsp_cfg_if.ctrl   cfg,
    output logic      out_valid_o
);

    localparam int LANE_W = $clog2(`DSP_LANES);
    localparam int WTAP_W = $clog2(`FFE_TAPS);
    localparam int CTAP_W = $clog2(`CHAN_TAPS);

    logic [4:0]        vld_q;
    logic [7:0]        lane_sel;
    logic [LANE_W-1:0] lane;
    logic [WTAP_W-1:0] wtap;
    logic [CTAP_W-1:0] ctap;
    logic              lane_ok;
    logic              wtap_ok;
    logic              ctap_ok;

    // Both views keep the lane in the top byte
    assign lane_sel = cfg_data_i.scalar.lane;

    assign lane    = lane_sel[LANE_W-1:0];
    assign lane_ok = int'(lane_sel) < `DSP_LANES;
    assign wtap    = cfg_data_i.tap.tap[WTAP_W-1:0];
    assign wtap_ok = int'(cfg_data_i.tap.tap) < `FFE_TAPS;
    assign ctap    = cfg_data_i.tap.tap[CTAP_W-1:0];
    assign ctap_ok = int'(cfg_data_i.tap.tap) < `CHAN_TAPS;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg.weight     <= '0;
            cfg.chan       <= '0;
            cfg.thresh     <= '0;
            cfg.ffe_shift  <= '0;
            cfg.chan_shift <= '0;
            cfg.align_pos  <= '0;
        end else if (cfg_we_i) begin
            case (cfg_kind_i)
                CFG_FFE_WEIGHT: begin
                    if (lane_ok && wtap_ok) begin
                        cfg.weight[lane][wtap] <= cfg_data_i.tap.value[`WEIGHT_W-1:0];
                    end
                end
                CFG_CHAN_TAP: begin
                    if (lane_ok && ctap_ok) begin
                        cfg.chan[lane][ctap] <= cfg_data_i.tap.value[`CHAN_W-1:0];
                    end
                end
                CFG_THRESH: begin
                    if (lane_ok) begin
                        cfg.thresh[lane] <= cfg_data_i.scalar.value[`FFE_OUT_W-1:0];
                    end
                end
                CFG_FFE_SHIFT: begin
                    if (lane_ok) begin
                        cfg.ffe_shift[lane] <= cfg_data_i.scalar.value[`SHIFT_W-1:0];
                    end
                end
                CFG_CHAN_SHIFT: begin
                    if (lane_ok) begin
                        cfg.chan_shift[lane] <= cfg_data_i.scalar.value[`SHIFT_W-1:0];
                    end
                end
                CFG_ALIGN: begin
                    cfg.align_pos <= cfg_data_i.scalar.value[$bits(align_t)-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // One bit per pipeline stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[3:0], adc_valid_i};
        end
    end

    assign cfg.v_ffe   = vld_q[0];
    assign cfg.v_slice = vld_q[1];
    assign cfg.v_chan  = vld_q[2];
    assign cfg.v_det   = vld_q[3];
    assign out_valid_o = vld_q[4];

endmodule

// File: verilog/dsp_cfg_if.sv
`include "dsp_defs.svh"

interface dsp_cfg_if
    import dsp_types_pkg::*;
    import dsp_cfg_pkg::*;
();

    weight_t  [`DSP_LANES-1:0][`FFE_TAPS-1:0]  weight;
    chan_t    [`DSP_LANES-1:0][`CHAN_TAPS-1:0] chan;
    ffe_out_t [`DSP_LANES-1:0]                 thresh;
    shift_t   [`DSP_LANES-1:0]                 ffe_shift;
    shift_t   [`DSP_LANES-1:0]                 chan_shift;
    align_t                                    align_pos;

    // Input strobe delayed one to four cycles
    logic v_ffe;
    logic v_slice;
    logic v_chan;
    logic v_det;

    modport ctrl (
        output weight, chan, thresh, ffe_shift, chan_shift, align_pos,
        output v_ffe, v_slice, v_chan, v_det
    );

    modport dp (
        input weight, chan, thresh, ffe_shift, chan_shift, align_pos,
        input v_ffe, v_slice, v_chan, v_det
    );

endinterface

// File: verilog/dsp_cfg_pkg.sv
`include "dsp_defs.svh"

package dsp_cfg_pkg;

    typedef enum logic [2:0] {
        CFG_FFE_WEIGHT = 3'd0,
        CFG_CHAN_TAP   = 3'd1,
        CFG_THRESH     = 3'd2,
        CFG_FFE_SHIFT  = 3'd3,
        CFG_CHAN_SHIFT = 3'd4,
        CFG_ALIGN      = 3'd5
    } cfg_kind_e;

    // Table entry types
    typedef logic signed [`WEIGHT_W-1:0] weight_t;
    typedef logic signed [`CHAN_W-1:0] chan_t;
    typedef logic [`SHIFT_W-1:0] shift_t;
    typedef logic [$clog2(`DSP_LANES)-1:0] align_t;

    // Weights and channel taps
    typedef struct packed {
        logic [7:0]         lane;
        logic [7:0]         tap;
        logic signed [15:0] value;
    } cfg_tap_t;

    // Thresholds, shifts, align position
    typedef struct packed {
        logic [7:0]         lane;
        logic signed [23:0] value;
    } cfg_scalar_t;

    typedef union packed {
        cfg_tap_t    tap;
        cfg_scalar_t scalar;
    } cfg_word_u;

endpackage

// File: verilog/dsp_types_pkg.sv
`include "dsp_defs.svh"

package dsp_types_pkg;

    // One ADC code
    typedef logic signed [`CODE_W-1:0] code_t;

    // One equalized value
    typedef logic signed [`FFE_OUT_W-1:0] ffe_out_t;

    // One rebuilt code and one error
    typedef logic signed [`EST_W-1:0] est_t;
    typedef logic signed [`ERR_W-1:0] err_t;

    // Detector choice: 0 none, 1 this bit, 2 this bit and the one before
    typedef logic [1:0] pos_t;

    // Word-wide buses, lane 0 is earliest in serial order
    typedef code_t [`DSP_LANES-1:0] code_word_t;
    typedef logic  [`DSP_LANES-1:0] bit_word_t;
    typedef err_t  [`DSP_LANES-1:0] err_word_t;
    typedef pos_t  [`DSP_LANES-1:0] pos_word_t;

endpackage

// File: verilog/dsp_defs.svh
`ifndef DSP_DEFS_SVH
`define DSP_DEFS_SVH

// Lanes per word
`define DSP_LANES 4

// ADC code width
`define CODE_W 8

// FFE taps and precisions
`define FFE_TAPS 3
`define WEIGHT_W 8
`define FFE_OUT_W 12
`define SHIFT_W 4

// Channel estimate taps and precisions
`define CHAN_TAPS 3
`define CHAN_W 8
`define EST_W 10

// Error width
`define ERR_W 10

`endif
